// File: logic/frontend_pkg.sv
// Frontend shared definitions
`default_nettype none

package frontend_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int unsigned PLEN        = 32;
  localparam int unsigned ILEN        = 32;
  localparam int unsigned FETCH_WIDTH = 2;
  localparam int unsigned LINE_WORDS  = 4;

  // ==============================
  // Data types
  // ==============================
  typedef logic [PLEN-1:0] addr_t;
  typedef logic [ILEN-1:0] instr_t;

  // Slot 0 holds the lower address
  typedef instr_t [FETCH_WIDTH-1:0] fetch_group_t;

  // Word k at byte offset 4k
  typedef logic [LINE_WORDS*ILEN-1:0] line_t;

  typedef logic [2:0]                     epoch_t;
  typedef logic [$clog2(FETCH_WIDTH)-1:0] slot_idx_t;

  // ==============================
  // State encodings
  // ==============================
  typedef enum logic [1:0] {IFU_REQ, IFU_WAIT, IFU_OUT} ifu_state_e;
  typedef enum logic [1:0] {IC_IDLE, IC_MISS_REQ, IC_REFILL, IC_RESP} icache_state_e;

endpackage : frontend_pkg

`default_nettype wire

// File: logic/frontend_ifs.sv
// Frontend internal links
`default_nettype none

// Fetch unit to branch predictor
interface bpu_if;
  import frontend_pkg::*;

  logic      req_valid;
  addr_t     req_pc;
  logic      pred_valid;
  addr_t     pred_npc;
  logic      pred_slot_valid;
  slot_idx_t pred_slot_idx;
  addr_t     pred_target;

  modport ifu (output req_valid, req_pc,
               input  pred_valid, pred_npc, pred_slot_valid, pred_slot_idx, pred_target);
  modport bpu (input  req_valid, req_pc,
               output pred_valid, pred_npc, pred_slot_valid, pred_slot_idx, pred_target);
endinterface : bpu_if

// Fetch unit to instruction cache
interface icache_if;
  import frontend_pkg::*;

  logic         req_valid;
  logic         req_ready;
  addr_t        req_pc;
  logic         flush;
  logic         rsp_valid;
  fetch_group_t rsp_data;

  modport ifu   (output req_valid, req_pc, flush,
                 input  req_ready, rsp_valid, rsp_data);
  modport cache (input  req_valid, req_pc, flush,
                 output req_ready, rsp_valid, rsp_data);
endinterface : icache_if

`default_nettype wire

// File: logic/bpu.sv
// Branch target buffer
`default_nettype none

module bpu #(
  parameter int unsigned BTB_ENTRIES = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  bpu_if.bpu                  bpu,
  input  logic                update_valid_i,
  input  logic                update_is_cond_i,
  input  logic                update_taken_i,
  input  frontend_pkg::addr_t update_pc_i,
  input  frontend_pkg::addr_t update_target_i
);
  import frontend_pkg::*;

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
  localparam int unsigned TAG_W = PLEN - 2 - IDX_W;

  logic [BTB_ENTRIES-1:0] btb_valid_q;
  logic [TAG_W-1:0]       btb_tag_q    [BTB_ENTRIES];
  addr_t                  btb_target_q [BTB_ENTRIES];
  logic [1:0]             btb_ctr_q    [BTB_ENTRIES];

  logic             look_taken;
  slot_idx_t        look_idx;
  addr_t            look_target;
  addr_t            look_npc;
  logic [IDX_W-1:0] upd_idx;
  logic             upd_hit;
  logic [1:0]       upd_ctr;

  // ==============================
  // Lookup
  // ==============================
  always_comb begin
    addr_t            slot_pc;
    logic [IDX_W-1:0] slot_idx;
    look_taken  = 1'b0;
    look_idx    = '0;
    look_target = '0;
    look_npc    = {bpu.req_pc[PLEN-1:3], 3'b000} + addr_t'(8);
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slot_pc  = {bpu.req_pc[PLEN-1:3], s[0], 2'b00};
      slot_idx = slot_pc[2 +: IDX_W];
      // Slots below the fetch PC are skipped; first taken slot wins
      if (!look_taken && slot_pc >= bpu.req_pc && btb_valid_q[slot_idx] &&
          btb_tag_q[slot_idx] == slot_pc[PLEN-1 -: TAG_W] && btb_ctr_q[slot_idx][1]) begin
        look_taken  = 1'b1;
        look_idx    = slot_idx_t'(s);
        look_target = btb_target_q[slot_idx];
        look_npc    = btb_target_q[slot_idx];
      end
    end
  end

  // Result one cycle after the request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bpu.pred_valid <= 1'b0;
    end else begin
      bpu.pred_valid <= bpu.req_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bpu.req_valid) begin
      bpu.pred_slot_valid <= look_taken;
      bpu.pred_slot_idx   <= look_idx;
      bpu.pred_target     <= look_target;
      bpu.pred_npc        <= look_npc;
    end
  end

  // ==============================
  // Training
  // ==============================
  assign upd_idx = update_pc_i[2 +: IDX_W];
  assign upd_hit = btb_valid_q[upd_idx] && btb_tag_q[upd_idx] == update_pc_i[PLEN-1 -: TAG_W];

  always_comb begin
    if (!update_is_cond_i) begin
      upd_ctr = 2'd3;
    end else if (!upd_hit) begin
      upd_ctr = update_taken_i ? 2'd2 : 2'd1;
    end else if (update_taken_i) begin
      upd_ctr = (btb_ctr_q[upd_idx] == 2'd3) ? 2'd3 : btb_ctr_q[upd_idx] + 2'd1;
    end else begin
      upd_ctr = (btb_ctr_q[upd_idx] == 2'd0) ? 2'd0 : btb_ctr_q[upd_idx] - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      btb_valid_q <= '0;
    end else if (update_valid_i) begin
      btb_valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      btb_tag_q[upd_idx]    <= update_pc_i[PLEN-1 -: TAG_W];
      btb_target_q[upd_idx] <= update_target_i;
      btb_ctr_q[upd_idx]    <= upd_ctr;
    end
  end

endmodule : bpu

`default_nettype wire

// File: logic/icache.sv
// Direct-mapped instruction cache
`default_nettype none

module icache #(
  parameter  int unsigned ICACHE_SETS = 8,
  localparam int unsigned IDX_W       = $clog2(ICACHE_SETS)
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  icache_if.cache             ifu,
  output logic                miss_req_valid_o,
  input  logic                miss_req_ready_i,
  output frontend_pkg::addr_t miss_req_paddr_o,
  output logic [IDX_W-1:0]    miss_req_index_o,
  input  logic                refill_valid_i,
  output logic                refill_ready_o,
  input  frontend_pkg::addr_t refill_paddr_i,
  input  frontend_pkg::line_t refill_data_i
);
  import frontend_pkg::*;

  localparam int unsigned TAG_W = PLEN - 4 - IDX_W;

  icache_state_e state_q;
  logic          lookup_q;
  logic          drop_q;
  addr_t         pc_q;

  logic [ICACHE_SETS-1:0] valid_q;
  logic [TAG_W-1:0]       tag_q  [ICACHE_SETS];
  line_t                  data_q [ICACHE_SETS];

  logic [IDX_W-1:0] idx;
  logic [IDX_W-1:0] refill_idx;
  line_t            rd_line;
  logic             hit;
  logic             req_fire;
  logic             refill_fire;

  assign idx         = pc_q[4 +: IDX_W];
  assign refill_idx  = refill_paddr_i[4 +: IDX_W];
  assign rd_line     = data_q[idx];
  assign hit         = valid_q[idx] && tag_q[idx] == pc_q[PLEN-1 -: TAG_W];
  assign req_fire    = ifu.req_valid && ifu.req_ready;
  assign refill_fire = refill_valid_i && refill_ready_o;

  // No new request while a lookup is in flight
  assign ifu.req_ready    = (state_q == IC_IDLE) && !lookup_q;
  assign miss_req_valid_o = (state_q == IC_MISS_REQ);
  assign miss_req_paddr_o = {pc_q[PLEN-1:4], 4'h0};
  assign miss_req_index_o = idx;
  assign refill_ready_o   = (state_q == IC_REFILL);

  // ==============================
  // Control FSM
  // ==============================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= IC_IDLE;
      lookup_q      <= 1'b0;
      drop_q        <= 1'b0;
      ifu.rsp_valid <= 1'b0;
    end else begin
      ifu.rsp_valid <= 1'b0;
      lookup_q      <= req_fire;
      unique case (state_q)
        IC_IDLE: begin
          drop_q <= 1'b0;
          if (lookup_q && !ifu.flush) begin
            if (hit) begin
              ifu.rsp_valid <= 1'b1;
            end else begin
              state_q <= IC_MISS_REQ;
            end
          end
        end
        IC_MISS_REQ: if (miss_req_ready_i) state_q <= IC_REFILL;
        IC_REFILL:   if (refill_fire) state_q <= IC_RESP;
        IC_RESP: begin
          // Refilled line is in the array now
          ifu.rsp_valid <= !drop_q && !ifu.flush;
          state_q       <= IC_IDLE;
        end
        default: state_q <= IC_IDLE;
      endcase
      // Miss keeps going but its answer is owed to nobody
      if (ifu.flush && state_q != IC_IDLE) drop_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) pc_q <= ifu.req_pc;
    // Half-line picked by address bit 3
    ifu.rsp_data <= rd_line[{pc_q[3], 6'd0} +: FETCH_WIDTH*ILEN];
  end

  // ==============================
  // Arrays
  // ==============================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (refill_fire) begin
      valid_q[refill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (refill_fire) begin
      tag_q[refill_idx]  <= refill_paddr_i[PLEN-1 -: TAG_W];
      data_q[refill_idx] <= refill_data_i;
    end
  end

endmodule : icache

`default_nettype wire

// File: logic/ifu.sv
// Instruction fetch unit
`default_nettype none

module ifu #(
  parameter frontend_pkg::addr_t RESET_PC = '0
) (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  bpu_if.ifu                                                bpu,
  icache_if.ifu                                             icache,
  input  logic                                              flush_i,
  input  frontend_pkg::addr_t                               redirect_pc_i,
  output logic                                              ibuffer_valid_o,
  input  logic                                              ibuffer_ready_i,
  output frontend_pkg::fetch_group_t                        ibuffer_data_o,
  output frontend_pkg::addr_t                               ibuffer_pc_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]              ibuffer_slot_valid_o,
  output frontend_pkg::addr_t [frontend_pkg::FETCH_WIDTH-1:0] ibuffer_pred_npc_o,
  output frontend_pkg::epoch_t                              ibuffer_fetch_epoch_o
);
  import frontend_pkg::*;

  ifu_state_e state_q;
  addr_t      pc_q;
  epoch_t     epoch_q;

  // Saved prediction
  logic      pred_slot_valid_q;
  slot_idx_t pred_slot_idx_q;
  addr_t     pred_target_q;
  addr_t     pred_npc_q;

  logic                         req_fire;
  logic                         out_fire;
  logic [FETCH_WIDTH-1:0]       slot_valid;
  addr_t [FETCH_WIDTH-1:0]      slot_npc;

  assign req_fire = icache.req_valid && icache.req_ready;
  assign out_fire = ibuffer_valid_o && ibuffer_ready_i;

  // Cache and BPU see the same request
  assign icache.req_valid = (state_q == IFU_REQ) && !flush_i;
  assign icache.req_pc    = pc_q;
  assign icache.flush     = flush_i;
  assign bpu.req_valid    = req_fire;
  assign bpu.req_pc       = pc_q;

  assign ibuffer_pc_o          = pc_q;
  assign ibuffer_fetch_epoch_o = epoch_q;

  always_comb begin
    for (int s = 0; s < FETCH_WIDTH; s++) begin
      slot_valid[s] = (s >= int'(pc_q[2]));
      slot_npc[s]   = {pc_q[PLEN-1:3], 3'b000} + addr_t'(4 * s + 4);
      if (pred_slot_valid_q && s > int'(pred_slot_idx_q)) slot_valid[s] = 1'b0;
      if (pred_slot_valid_q && s == int'(pred_slot_idx_q)) slot_npc[s] = pred_target_q;
    end
  end

  // ==============================
  // Fetch FSM
  // ==============================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q         <= IFU_REQ;
      pc_q            <= RESET_PC;
      epoch_q         <= '0;
      ibuffer_valid_o <= 1'b0;
    end else if (flush_i) begin
      state_q         <= IFU_REQ;
      pc_q            <= redirect_pc_i;
      epoch_q         <= epoch_q + 3'd1;
      ibuffer_valid_o <= 1'b0;
    end else begin
      unique case (state_q)
        IFU_REQ:  if (req_fire) state_q <= IFU_WAIT;
        IFU_WAIT: begin
          if (icache.rsp_valid) begin
            state_q         <= IFU_OUT;
            ibuffer_valid_o <= 1'b1;
          end
        end
        IFU_OUT: begin
          if (out_fire) begin
            state_q         <= IFU_REQ;
            ibuffer_valid_o <= 1'b0;
            pc_q            <= pred_npc_q;
          end
        end
        default: state_q <= IFU_REQ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IFU_WAIT && bpu.pred_valid) begin
      pred_slot_valid_q <= bpu.pred_slot_valid;
      pred_slot_idx_q   <= bpu.pred_slot_idx;
      pred_target_q     <= bpu.pred_target;
      pred_npc_q        <= bpu.pred_npc;
    end
    if (state_q == IFU_WAIT && icache.rsp_valid) begin
      ibuffer_data_o       <= icache.rsp_data;
      ibuffer_slot_valid_o <= slot_valid;
      ibuffer_pred_npc_o   <= slot_npc;
    end
  end

endmodule : ifu

`default_nettype wire

// File: logic/frontend.sv
// Instruction front end top
`default_nettype none

module frontend #(
  parameter int unsigned         ICACHE_SETS = 8,
  parameter int unsigned         BTB_ENTRIES = 8,
  parameter frontend_pkg::addr_t RESET_PC    = '0
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,

  // ==============================
  // Backend side
  // ==============================
  output logic                                                ibuffer_valid_o,
  input  logic                                                ibuffer_ready_i,
  output frontend_pkg::fetch_group_t                          ibuffer_data_o,
  output frontend_pkg::addr_t                                 ibuffer_pc_o,
  output logic [frontend_pkg::FETCH_WIDTH-1:0]                ibuffer_slot_valid_o,
  output frontend_pkg::addr_t [frontend_pkg::FETCH_WIDTH-1:0] ibuffer_pred_npc_o,
  output frontend_pkg::epoch_t                                ibuffer_fetch_epoch_o,
  input  logic                                                flush_i,
  input  frontend_pkg::addr_t                                 redirect_pc_i,
  input  logic                                                update_valid_i,
  input  logic                                                update_is_cond_i,
  input  logic                                                update_taken_i,
  input  frontend_pkg::addr_t                                 update_pc_i,
  input  frontend_pkg::addr_t                                 update_target_i,

  // ==============================
  // Memory side
  // ==============================
  output logic                                                miss_req_valid_o,
  input  logic                                                miss_req_ready_i,
  output frontend_pkg::addr_t                                 miss_req_paddr_o,
  output logic [$clog2(ICACHE_SETS)-1:0]                      miss_req_index_o,
  input  logic                                                refill_valid_i,
  output logic                                                refill_ready_o,
  input  frontend_pkg::addr_t                                 refill_paddr_i,
  input  frontend_pkg::line_t                                 refill_data_i
);

  bpu_if    bpu_bus ();
  icache_if icache_bus ();

  ifu #(
    .RESET_PC(RESET_PC)
  ) i_ifu (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .bpu                  (bpu_bus.ifu),
    .icache               (icache_bus.ifu),
    .flush_i              (flush_i),
    .redirect_pc_i        (redirect_pc_i),
    .ibuffer_valid_o      (ibuffer_valid_o),
    .ibuffer_ready_i      (ibuffer_ready_i),
    .ibuffer_data_o       (ibuffer_data_o),
    .ibuffer_pc_o         (ibuffer_pc_o),
    .ibuffer_slot_valid_o (ibuffer_slot_valid_o),
    .ibuffer_pred_npc_o   (ibuffer_pred_npc_o),
    .ibuffer_fetch_epoch_o(ibuffer_fetch_epoch_o)
  );

  bpu #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) i_bpu (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .bpu             (bpu_bus.bpu),
    .update_valid_i  (update_valid_i),
    .update_is_cond_i(update_is_cond_i),
    .update_taken_i  (update_taken_i),
    .update_pc_i     (update_pc_i),
    .update_target_i (update_target_i)
  );

  icache #(
    .ICACHE_SETS(ICACHE_SETS)
  ) i_icache (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .ifu             (icache_bus.cache),
    .miss_req_valid_o(miss_req_valid_o),
    .miss_req_ready_i(miss_req_ready_i),
    .miss_req_paddr_o(miss_req_paddr_o),
    .miss_req_index_o(miss_req_index_o),
    .refill_valid_i  (refill_valid_i),
    .refill_ready_o  (refill_ready_o),
    .refill_paddr_i  (refill_paddr_i),
    .refill_data_i   (refill_data_i)
  );

endmodule : frontend

`default_nettype wire

// File: bench/frontend_props.sv
// Frontend protocol properties
`default_nettype none

module frontend_props (
  input wire logic        clk_i,
  input wire logic        rst_n_i,
  input wire logic        miss_req_valid_o,
  input wire logic        miss_req_ready_i,
  input wire logic [31:0] miss_req_paddr_o,
  input wire logic        refill_ready_o,
  input wire logic        ibuffer_valid_o,
  input wire logic        ibuffer_ready_i,
  input wire logic [63:0] ibuffer_data_o,
  input wire logic [31:0] ibuffer_pc_o,
  input wire logic        flush_i
);

  int fail_count = 0;

  // Miss request held with a stable address until taken
  miss_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    miss_req_valid_o && !miss_req_ready_i |=> miss_req_valid_o && $stable(miss_req_paddr_o))
    else begin
      $error("miss request dropped or changed before ready");
      fail_count++;
    end

  // Held group stays put until taken or flushed
  ibuffer_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ibuffer_valid_o && !ibuffer_ready_i && !flush_i |=>
      ibuffer_valid_o && $stable(ibuffer_data_o) && $stable(ibuffer_pc_o))
    else begin
      $error("ibuffer output changed under back-pressure");
      fail_count++;
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !ibuffer_valid_o && !miss_req_valid_o && !refill_ready_o)
    else begin
      $error("valid output high during reset");
      fail_count++;
    end

endmodule : frontend_props

`default_nettype wire

// File: bench/frontend_tb.sv
// Frontend testbench
`default_nettype none

module frontend_tb;
  import frontend_pkg::*;

  localparam int    TIMEOUT = 400;
  localparam addr_t KEY     = 32'h13579BDF;

  logic clk_i, rst_n_i, ibuffer_valid_o, ibuffer_ready_i, flush_i;
  logic update_valid_i, update_is_cond_i, update_taken_i;
  logic miss_req_valid_o, miss_req_ready_i, refill_valid_i, refill_ready_o;
  fetch_group_t         ibuffer_data_o;
  addr_t                ibuffer_pc_o, redirect_pc_i, update_pc_i, update_target_i;
  addr_t                miss_req_paddr_o, refill_paddr_i;
  addr_t [1:0]          ibuffer_pred_npc_o;
  logic [1:0]           ibuffer_slot_valid_o;
  logic [2:0]           miss_req_index_o;
  epoch_t               ibuffer_fetch_epoch_o, cur_epoch;
  line_t                refill_data_i;

  int         seed = 32'h92c9;
  int         errors = 0;
  logic       bp_on = 1'b0;
  addr_t      miss_log[$];
  logic [2:0] idx_log[$];
  addr_t      first_pcs[$];
  // Reference BTB
  logic       ref_valid[8];
  addr_t      ref_pc[8];
  addr_t      ref_tgt[8];
  logic [1:0] ref_ctr[8];

  frontend DUT (.*);

  bind frontend frontend_props props_i (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .miss_req_valid_o(miss_req_valid_o),
    .miss_req_ready_i(miss_req_ready_i), .miss_req_paddr_o(miss_req_paddr_o),
    .refill_ready_o(refill_ready_o), .ibuffer_valid_o(ibuffer_valid_o),
    .ibuffer_ready_i(ibuffer_ready_i), .ibuffer_data_o(ibuffer_data_o),
    .ibuffer_pc_o(ibuffer_pc_o), .flush_i(flush_i));

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ==============================
  // Memory model
  // ==============================
  int    mem_state;
  int    mem_dly;
  addr_t mem_addr;

  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      mem_state = 0;
      mem_dly   = 0;
    end else begin
      case (mem_state)
        0: begin
          miss_req_ready_i = 1'b0;
          if (miss_req_valid_o) begin
            if (mem_dly == 0) begin
              miss_req_ready_i = 1'b1;
              mem_addr         = miss_req_paddr_o;
              miss_log.push_back(mem_addr);
              idx_log.push_back(miss_req_index_o);
              mem_dly          = $unsigned($random(seed)) % 4;
              mem_state        = 1;
            end else begin
              mem_dly--;
            end
          end
        end
        1: begin
          miss_req_ready_i = 1'b0;
          if (mem_dly == 0) begin
            // Cache sits in refill since the miss request was taken
            assert (refill_ready_o) else begin
              errors++;
              $display("refill ready was low while a refill was owed");
            end
            refill_valid_i = 1'b1;
            refill_paddr_i = mem_addr;
            for (int k = 0; k < 4; k++) refill_data_i[32*k +: 32] = (mem_addr + 4 * k) ^ KEY;
            mem_state = 2;
          end else begin
            mem_dly--;
          end
        end
        default: begin
          refill_valid_i = 1'b0;
          mem_dly        = $unsigned($random(seed)) % 4;
          mem_state      = 0;
        end
      endcase
    end
  end

  task automatic compare_field(input string name, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic btb_update(input addr_t pc, input addr_t tgt, input logic taken);
    logic [2:0] i;
    i = pc[4:2];
    @(negedge clk_i);
    {update_valid_i, update_is_cond_i, update_taken_i} = {2'b11, taken};
    update_pc_i     = pc;
    update_target_i = tgt;
    if (!(ref_valid[i] && ref_pc[i] == pc)) ref_ctr[i] = taken ? 2'd2 : 2'd1;
    else if (taken && ref_ctr[i] != 2'd3) ref_ctr[i]++;
    else if (!taken && ref_ctr[i] != 2'd0) ref_ctr[i]--;
    {ref_valid[i], ref_pc[i], ref_tgt[i]} = {1'b1, pc, tgt};
    @(negedge clk_i);
    update_valid_i = 1'b0;
  endtask

  task automatic redirect(input addr_t pc);
    @(negedge clk_i);
    {flush_i, ibuffer_ready_i, redirect_pc_i} = {2'b10, pc};
    @(negedge clk_i);
    flush_i   = 1'b0;
    cur_epoch = cur_epoch + 3'd1;
  endtask

  // Takes one group with ready driven per cycle
  task automatic expect_group(input string name, input addr_t exp_pc, output addr_t next_pc);
    addr_t       base, spc;
    logic [1:0]  exp_sv;
    addr_t [1:0] exp_npc;
    logic        taken, got;
    int          cyc;
    got = 1'b0;
    cyc = 0;
    next_pc = exp_pc;
    while (!got && cyc < TIMEOUT) begin
      @(negedge clk_i);
      ibuffer_ready_i = bp_on ? (($random(seed) & 3) == 0) : 1'b1;
      got = ibuffer_valid_o && ibuffer_ready_i;
      cyc++;
    end
    assert (got) else begin
      errors++;
      $display("%s: no ibuffer group arrived in time", name);
    end
    if (!got) return;
    base    = {exp_pc[31:3], 3'b000};
    taken   = 1'b0;
    next_pc = base + 8;
    for (int s = 0; s < 2; s++) begin
      spc        = base + 4 * s;
      exp_sv[s]  = spc >= exp_pc && !taken;
      exp_npc[s] = spc + 4;
      if (exp_sv[s] && ref_valid[spc[4:2]] && ref_pc[spc[4:2]] == spc &&
          ref_ctr[spc[4:2]] >= 2) begin
        taken      = 1'b1;
        exp_npc[s] = ref_tgt[spc[4:2]];
        next_pc    = ref_tgt[spc[4:2]];
      end
    end
    compare_field(name, "pc", exp_pc, ibuffer_pc_o);
    compare_field(name, "epoch", cur_epoch, ibuffer_fetch_epoch_o);
    compare_field(name, "data", {(base + 4) ^ KEY, base ^ KEY}, ibuffer_data_o);
    compare_field(name, "slot valid", exp_sv, ibuffer_slot_valid_o);
    for (int s = 0; s < 2; s++)
      if (exp_sv[s]) compare_field(name, "pred npc", exp_npc[s], ibuffer_pred_npc_o[s]);
  endtask

  function automatic int misses_in(input int from, input addr_t lo, input addr_t hi);
    int n;
    n = 0;
    for (int i = from; i < miss_log.size(); i++)
      if (miss_log[i] >= lo && miss_log[i] < hi) n++;
    return n;
  endfunction

  // ==============================
  // Directed tests
  // ==============================
  task automatic run_path(input string name, input addr_t start, input int groups,
                          input logic record, input logic replay);
    addr_t pc;
    pc = start;
    for (int g = 0; g < groups; g++) begin
      expect_group(name, pc, pc);
      if (record) first_pcs.push_back(ibuffer_pc_o);
      if (replay && g < first_pcs.size()) begin
        compare_field(name, "path", first_pcs[g], ibuffer_pc_o);
      end
    end
  endtask

  task automatic cold_fetch();
    run_path("cold_fetch", 32'h0, 8, 1'b1, 1'b0);
    compare_field("cold_fetch", "miss count", 4, misses_in(0, 0, 32'h40));
    for (int i = 0; i < 4; i++) compare_field("cold_fetch", "miss addr", 16 * i, miss_log[i]);
    for (int i = 0; i < 4; i++) compare_field("cold_fetch", "miss index", i, idx_log[i]);
  endtask

  task automatic hit_reuse();
    int mark;
    mark = miss_log.size();
    redirect(32'h0);
    run_path("hit_reuse", 32'h0, 8, 1'b0, 1'b1);
    compare_field("hit_reuse", "miss count", 0, misses_in(mark, 0, 32'h40));
  endtask

  task automatic back_pressure();
    int mark;
    redirect(32'h80);
    run_path("evict", 32'h80, 8, 1'b0, 1'b0);
    mark  = miss_log.size();
    bp_on = 1'b1;
    redirect(32'h0);
    run_path("back_pressure", 32'h0, 8, 1'b0, 1'b1);
    bp_on = 1'b0;
    compare_field("back_pressure", "miss count", 4, misses_in(mark, 0, 32'h40));
  endtask

  task automatic unaligned_start();
    addr_t nxt;
    redirect(32'h104);
    expect_group("unaligned", 32'h104, nxt);
    expect_group("unaligned", 32'h108, nxt);
  endtask

  task automatic branch_training();
    addr_t nxt;
    btb_update(32'h300, 32'h340, 1'b1);
    btb_update(32'h300, 32'h340, 1'b1);
    redirect(32'h300);
    expect_group("taken", 32'h300, nxt);
    expect_group("taken", 32'h340, nxt);
    btb_update(32'h300, 32'h340, 1'b0);
    btb_update(32'h300, 32'h340, 1'b0);
    redirect(32'h300);
    expect_group("not_taken", 32'h300, nxt);
    expect_group("not_taken", 32'h308, nxt);
  endtask

  task automatic flush_in_miss();
    addr_t nxt;
    int    cyc;
    redirect(32'h400);
    cyc = 0;
    while (!miss_req_valid_o && cyc < TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    assert (miss_req_valid_o) else begin
      errors++;
      $display("flush_in_miss: the miss request never appeared");
    end
    redirect(32'h480);
    expect_group("flush_in_miss", 32'h480, nxt);
  endtask

  initial begin
    {rst_n_i, flush_i, ibuffer_ready_i, update_valid_i} = '0;
    {update_is_cond_i, update_taken_i, miss_req_ready_i, refill_valid_i} = '0;
    {redirect_pc_i, update_pc_i, update_target_i, refill_paddr_i} = '0;
    refill_data_i = '0;
    cur_epoch     = '0;
    for (int i = 0; i < 8; i++) {ref_valid[i], ref_ctr[i]} = '0;
    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;
    cold_fetch();
    hit_reuse();
    back_pressure();
    unaligned_start();
    branch_training();
    flush_in_miss();
    errors += DUT.props_i.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : frontend_tb

`default_nettype wire

// File: all.f
logic/frontend_pkg.sv
logic/frontend_ifs.sv
logic/bpu.sv
logic/icache.sv
logic/ifu.sv
logic/frontend.sv
bench/frontend_props.sv
bench/frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /TESTS PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
